// File: common/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// instruction byte
`define INST_W      8

// register file select
`define REG_SEL_W   2

// branch and data memory address
`define ADDR_W      11

// address bits carried in the first byte
`define ADDR_HI_W   3

// bcnz and bcz both clear
`define CR_RESET    2'b00

`endif

// File: common/isa_pkg.sv
package isa_pkg;

    // bits 7..5 of a first byte
    typedef enum logic [2:0] {
        OP_CTRL = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_AND  = 3'd3,
        OP_OR   = 3'd4,
        OP_XOR  = 3'd5,
        OP_LD   = 3'd6,
        OP_ST   = 3'd7
    } base_op_e;

    // bits 4..3 under OP_CTRL
    typedef enum logic [1:0] {
        SUB_MISC = 2'd0,
        SUB_USR  = 2'd1,   // not implemented
        SUB_JMP  = 2'd2,
        SUB_CALL = 2'd3
    } ctrl_subop_e;

    // bits 2..0 under SUB_MISC where code 7 is undefined
    typedef enum logic [2:0] {
        MISC_NOP      = 3'd0,
        MISC_RET      = 3'd1,
        MISC_HALT     = 3'd2,
        MISC_RST      = 3'd3,
        MISC_SET_BCZ  = 3'd4,
        MISC_SET_BCNZ = 3'd5,
        MISC_CLR_BC   = 3'd6
    } misc_op_e;

    // command to the execute stage
    typedef enum logic [3:0] {
        EXEC_NOP      = 4'd0,
        EXEC_IDLE     = 4'd1,
        EXEC_ALU_ADD  = 4'd2,
        EXEC_ALU_SUB  = 4'd3,
        EXEC_ALU_AND  = 4'd4,
        EXEC_ALU_OR   = 4'd5,
        EXEC_ALU_XOR  = 4'd6,
        EXEC_MEM_RD   = 4'd7,
        EXEC_MEM_WR   = 4'd8,
        EXEC_CPU_JMP  = 4'd9,
        EXEC_CPU_CALL = 4'd10,
        EXEC_CPU_RET  = 4'd11
    } exec_op_e;

endpackage

// File: common/decode_pkg.sv
`include "decode_cfg.svh"

package decode_pkg;

    typedef enum logic [1:0] {
        CU_NONE     = 2'd0,
        CU_SET_BCZ  = 2'd1,
        CU_SET_BCNZ = 2'd2,
        CU_CLEAR    = 2'd3
    } cond_update_e;

    typedef struct packed {
        logic [2:0] reserved;
        logic       trap;
        logic       z;
        logic       nz;
        logic       stack_ovf;
        logic       ovf;
    } status_reg_t;

    // branch condition bits of the control register
    typedef struct packed {
        logic bcnz;
        logic bcz;
    } ctrl_reg_t;

    typedef struct packed {
        isa_pkg::exec_op_e     op;
        logic [`REG_SEL_W-1:0] src0_sel;
        logic                  src0_rd_en;
        logic [`REG_SEL_W-1:0] src1_sel;
        logic                  src1_rd_en;
        logic [`REG_SEL_W-1:0] dst_sel;
        logic                  needs_operand;  // second byte follows
        logic                  is_jump;
        logic                  is_call;
        logic [`ADDR_HI_W-1:0] addr_hi;
        logic                  halt;
        logic                  soft_rst;
        logic                  ret;
        cond_update_e          cond_update;
        logic                  illegal;
    } decoded_inst_t;

    typedef struct packed {
        isa_pkg::exec_op_e     op;
        logic [`REG_SEL_W-1:0] src0_sel;
        logic                  src0_rd_en;
        logic [`REG_SEL_W-1:0] src1_sel;
        logic                  src1_rd_en;
        logic [`REG_SEL_W-1:0] dst_sel;
        logic [`INST_W-1:0]    imm_val;
        logic                  imm_valid;
        logic [`ADDR_W-1:0]    addr;
        logic                  exec_en;
    } exec_cmd_t;

    typedef struct packed {
        logic call;
        logic branch;
        logic ret;
        logic soft_rst;
        logic halted;
        logic exec_en;
        logic fetch_en;
    } cpu_ctrl_cmd_t;

endpackage

// File: decode/opcode_decoder.sv
`timescale 1ns/10ps

`include "decode_cfg.svh"

module opcode_decoder (
    input  logic [`INST_W-1:0]        inst,
    output decode_pkg::decoded_inst_t decoded
);

    isa_pkg::base_op_e     base_op;
    isa_pkg::ctrl_subop_e  subop;
    isa_pkg::misc_op_e     misc_op;
    isa_pkg::exec_op_e     alu_op;
    logic                  imm;
    logic [`REG_SEL_W-1:0] reg_a;
    logic [`REG_SEL_W-1:0] reg_b;
    logic [`REG_SEL_W-1:0] ls_reg;

    assign base_op = isa_pkg::base_op_e'(inst[7:5]);
    assign subop   = isa_pkg::ctrl_subop_e'(inst[4:3]);
    assign misc_op = isa_pkg::misc_op_e'(inst[2:0]);
    assign imm     = inst[4];      // alu immediate form
    assign reg_a   = inst[3:2];
    assign reg_b   = inst[1:0];
    assign ls_reg  = inst[4:3];    // ld/st register

    always_comb begin
        case (base_op)
            isa_pkg::OP_ADD: alu_op = isa_pkg::EXEC_ALU_ADD;
            isa_pkg::OP_SUB: alu_op = isa_pkg::EXEC_ALU_SUB;
            isa_pkg::OP_AND: alu_op = isa_pkg::EXEC_ALU_AND;
            isa_pkg::OP_OR:  alu_op = isa_pkg::EXEC_ALU_OR;
            isa_pkg::OP_XOR: alu_op = isa_pkg::EXEC_ALU_XOR;
            default:         alu_op = isa_pkg::EXEC_NOP;
        endcase
    end

    always_comb begin
        decoded         = '0;
        decoded.addr_hi = inst[`ADDR_HI_W-1:0];
        case (base_op)
            isa_pkg::OP_CTRL: begin
                case (subop)
                    isa_pkg::SUB_MISC: begin
                        case (misc_op)
                            isa_pkg::MISC_NOP: decoded.op = isa_pkg::EXEC_NOP;
                            isa_pkg::MISC_RET: begin
                                decoded.op  = isa_pkg::EXEC_CPU_RET;
                                decoded.ret = 1'b1;
                            end
                            isa_pkg::MISC_HALT: decoded.halt = 1'b1;
                            isa_pkg::MISC_RST:  decoded.soft_rst = 1'b1;
                            isa_pkg::MISC_SET_BCZ: begin
                                decoded.op          = isa_pkg::EXEC_IDLE;
                                decoded.cond_update = decode_pkg::CU_SET_BCZ;
                            end
                            isa_pkg::MISC_SET_BCNZ: begin
                                decoded.op          = isa_pkg::EXEC_IDLE;
                                decoded.cond_update = decode_pkg::CU_SET_BCNZ;
                            end
                            isa_pkg::MISC_CLR_BC: begin
                                decoded.op          = isa_pkg::EXEC_IDLE;
                                decoded.cond_update = decode_pkg::CU_CLEAR;
                            end
                            default: decoded.illegal = 1'b1;  // code 7
                        endcase
                    end
                    isa_pkg::SUB_USR: decoded.illegal = 1'b1;
                    isa_pkg::SUB_JMP: begin
                        decoded.op            = isa_pkg::EXEC_CPU_JMP;
                        decoded.is_jump       = 1'b1;
                        decoded.needs_operand = 1'b1;  // low address byte
                    end
                    default: begin
                        decoded.op            = isa_pkg::EXEC_CPU_CALL;
                        decoded.is_call       = 1'b1;
                        decoded.needs_operand = 1'b1;
                    end
                endcase
            end
            isa_pkg::OP_LD: begin
                decoded.op            = isa_pkg::EXEC_MEM_RD;
                decoded.dst_sel       = ls_reg;
                decoded.needs_operand = 1'b1;
            end
            isa_pkg::OP_ST: begin
                decoded.op            = isa_pkg::EXEC_MEM_WR;
                decoded.src0_sel      = ls_reg;
                decoded.src0_rd_en    = 1'b1;
                decoded.needs_operand = 1'b1;
            end
            default: begin
                // alu result always lands in reg_b
                decoded.op            = alu_op;
                decoded.src0_sel      = reg_a;
                decoded.src0_rd_en    = 1'b1;
                decoded.dst_sel       = reg_b;
                decoded.needs_operand = imm;
                if (!imm) begin
                    decoded.src1_sel   = reg_b;
                    decoded.src1_rd_en = 1'b1;
                end
            end
        endcase
    end

endmodule

// File: decode/operand_sequencer.sv
`timescale 1ns/10ps

`include "decode_cfg.svh"

module operand_sequencer (
    input  logic                      clk,
    input  logic                      reset_,
    input  logic                      inst_valid,
    input  logic [`INST_W-1:0]        inst,
    input  decode_pkg::decoded_inst_t decoded,
    input  logic                      take_branch,
    output decode_pkg::cond_update_e  cond_update,
    output decode_pkg::exec_cmd_t     exec_cmd,
    output decode_pkg::cpu_ctrl_cmd_t ctrl_cmd,
    output logic                      illegal_inst
);

    logic                      awaiting;      // next byte is an operand
    logic                      awaiting_nxt;
    decode_pkg::decoded_inst_t saved;         // first byte of a pair
    logic                      first_byte;
    logic                      second_byte;
    logic                      saved_is_alu;
    logic                      illegal_nxt;
    decode_pkg::exec_cmd_t     exec_nxt;
    decode_pkg::cpu_ctrl_cmd_t ctrl_nxt;

    assign first_byte   = inst_valid && !awaiting;
    assign second_byte  = inst_valid && awaiting;
    assign cond_update  = first_byte ? decoded.cond_update : decode_pkg::CU_NONE;
    assign saved_is_alu = saved.op inside {isa_pkg::EXEC_ALU_ADD, isa_pkg::EXEC_ALU_SUB,
                                           isa_pkg::EXEC_ALU_AND, isa_pkg::EXEC_ALU_OR,
                                           isa_pkg::EXEC_ALU_XOR};
    assign illegal_nxt  = first_byte && decoded.illegal;

    always_comb begin
        awaiting_nxt = awaiting;
        exec_nxt     = exec_cmd;   // op, selects, imm and addr hold
        ctrl_nxt     = ctrl_cmd;

        exec_nxt.exec_en    = 1'b0;
        exec_nxt.src0_rd_en = 1'b0;
        exec_nxt.src1_rd_en = 1'b0;
        exec_nxt.imm_valid  = 1'b0;
        ctrl_nxt.call       = 1'b0;
        ctrl_nxt.branch     = 1'b0;
        ctrl_nxt.ret        = 1'b0;
        ctrl_nxt.soft_rst   = 1'b0;
        ctrl_nxt.halted     = 1'b0;
        ctrl_nxt.exec_en    = 1'b0;

        if (first_byte) begin
            awaiting_nxt        = decoded.needs_operand;
            exec_nxt.op         = decoded.op;
            exec_nxt.src0_sel   = decoded.src0_sel;
            exec_nxt.src0_rd_en = decoded.src0_rd_en;
            exec_nxt.src1_sel   = decoded.src1_sel;
            exec_nxt.src1_rd_en = decoded.src1_rd_en;
            exec_nxt.dst_sel    = decoded.dst_sel;
            exec_nxt.exec_en    = 1'b1;
            ctrl_nxt.exec_en    = 1'b1;
            ctrl_nxt.ret        = decoded.ret;
            ctrl_nxt.soft_rst   = decoded.soft_rst;
            ctrl_nxt.halted     = decoded.halt;
            if (decoded.halt || decoded.ret) begin
                ctrl_nxt.fetch_en = 1'b0;   // stall fetch
            end
        end else if (second_byte) begin
            awaiting_nxt       = 1'b0;
            exec_nxt.imm_valid = 1'b1;
            if (saved_is_alu) begin
                exec_nxt.imm_val = inst;
            end else begin
                exec_nxt.addr = {saved.addr_hi, inst};   // ld/st/jmp/call
            end
            ctrl_nxt.branch = saved.is_jump && take_branch;
            ctrl_nxt.call   = saved.is_call && take_branch;
            if (saved.is_jump || saved.is_call) begin
                ctrl_nxt.fetch_en = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            awaiting     <= 1'b0;
            exec_cmd     <= '0;
            ctrl_cmd     <= '{fetch_en: 1'b1, default: 1'b0};
            illegal_inst <= 1'b0;
        end else begin
            awaiting     <= awaiting_nxt;
            exec_cmd     <= exec_nxt;
            ctrl_cmd     <= ctrl_nxt;
            illegal_inst <= illegal_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (first_byte) begin
            saved <= decoded;
        end
    end

endmodule

// File: logic/branch_condition.sv
`timescale 1ns/10ps

`include "decode_cfg.svh"

module branch_condition (
    input  logic                     clk,
    input  logic                     reset_,
    input  decode_pkg::cond_update_e cond_update,
    input  decode_pkg::status_reg_t  status,
    output logic                     take_branch
);

    decode_pkg::ctrl_reg_t cr;

    always_ff @(posedge clk) begin
        if (!reset_) begin
            cr <= `CR_RESET;
        end else begin
            case (cond_update)
                decode_pkg::CU_SET_BCZ: begin
                    cr.bcz  <= 1'b1;
                    cr.bcnz <= 1'b0;
                end
                decode_pkg::CU_SET_BCNZ: begin
                    cr.bcz  <= 1'b0;
                    cr.bcnz <= 1'b1;
                end
                decode_pkg::CU_CLEAR: begin
                    cr.bcz  <= 1'b0;
                    cr.bcnz <= 1'b0;
                end
                default: cr <= cr;   // no update
            endcase
        end
    end

    // unconditional when both bits clear
    assign take_branch = !(cr.bcz || cr.bcnz)
                      || (cr.bcnz && status.nz)
                      || (cr.bcz && status.z);

endmodule

// File: logic/inst_decode.sv
`timescale 1ns/10ps

`include "decode_cfg.svh"

module inst_decode (
    input  logic                      clk,
    input  logic                      reset_,
    input  logic                      inst_valid,
    input  logic [`INST_W-1:0]        inst,
    input  decode_pkg::status_reg_t   status,
    output decode_pkg::exec_cmd_t     exec_cmd,
    output decode_pkg::cpu_ctrl_cmd_t ctrl_cmd,
    output logic                      illegal_inst
);

    decode_pkg::decoded_inst_t decoded;
    decode_pkg::cond_update_e  cond_update;
    logic                      take_branch;

    // first-byte decode used only while no operand is pending
    opcode_decoder u_opcode_decoder (
        .inst    (inst),
        .decoded (decoded)
    );

    operand_sequencer u_operand_sequencer (
        .clk          (clk),
        .reset_       (reset_),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .decoded      (decoded),
        .take_branch  (take_branch),
        .cond_update  (cond_update),
        .exec_cmd     (exec_cmd),
        .ctrl_cmd     (ctrl_cmd),
        .illegal_inst (illegal_inst)
    );

    branch_condition u_branch_condition (
        .clk         (clk),
        .reset_      (reset_),
        .cond_update (cond_update),
        .status      (status),
        .take_branch (take_branch)
    );

endmodule

// File: testbench/inst_decode_chk.sv
`timescale 1ns/10ps

module inst_decode_chk (
    input logic                      clk,
    input logic                      reset_,
    input logic                      inst_valid,
    input decode_pkg::decoded_inst_t decoded,
    input decode_pkg::exec_cmd_t     exec_cmd,
    input decode_pkg::cpu_ctrl_cmd_t ctrl_cmd,
    input logic                      illegal_inst
);

    logic armed;   // operand byte expected next
    logic any_strobe;

    assign any_strobe = ctrl_cmd.call || ctrl_cmd.branch || ctrl_cmd.ret
                     || ctrl_cmd.soft_rst || ctrl_cmd.halted || ctrl_cmd.exec_en
                     || exec_cmd.exec_en || exec_cmd.imm_valid || illegal_inst;

    always_ff @(posedge clk) begin
        if (!reset_) begin
            armed <= 1'b0;
        end else if (inst_valid) begin
            armed <= !armed && decoded.needs_operand;
        end
    end

    branch_call_excl: assert property (@(posedge clk) disable iff (!reset_)
        !(ctrl_cmd.branch && ctrl_cmd.call))
        else $error("branch and call high together");

    imm_after_first: assert property (@(posedge clk) disable iff (!reset_)
        exec_cmd.imm_valid |-> $past(armed && inst_valid))
        else $error("imm_valid without an operand-needing first byte");

    quiet_in_reset: assert property (@(posedge clk)
        (!reset_ && $past(!reset_)) |-> !any_strobe)
        else $error("strobe high during reset");

endmodule

// File: testbench/inst_decode_monitor.sv
`timescale 1ns/10ps

`include "decode_cfg.svh"

module inst_decode_monitor (
    input  logic                      clk,
    input  logic                      exp_valid,
    input  logic [7:0]                exp_test,
    input  logic [7:0]                exp_mask,
    input  logic [3:0]                exp_op,
    input  logic [5:0]                exp_sel,
    input  logic [1:0]                exp_rd,
    input  logic [7:0]                exp_imm,
    input  logic [10:0]               exp_addr,
    input  logic [7:0]                exp_strobes,
    input  logic                      exp_fetch,
    input  decode_pkg::exec_cmd_t     exec_cmd,
    input  decode_pkg::cpu_ctrl_cmd_t ctrl_cmd,
    input  logic                      illegal_inst,
    input  logic                      report_req,
    output logic                      report_done,
    output int                        error_count
);

    logic        pend_valid = 1'b0;
    logic [7:0]  pend_test;
    logic [7:0]  pend_mask;
    logic [7:0]  pend_imm;
    logic [7:0]  pend_strobes;
    logic [3:0]  pend_op;
    logic [5:0]  pend_sel;
    logic [1:0]  pend_rd;
    logic [10:0] pend_addr;
    logic        pend_fetch;
    logic        have_test = 1'b0;
    logic [7:0]  cur_test;
    int          test_errors  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;

    initial begin
        report_done = 1'b0;
        error_count = 0;
    end

    // outputs answer one cycle after the byte
    always @(posedge clk) begin
        pend_valid   <= exp_valid;
        pend_test    <= exp_test;
        pend_mask    <= exp_mask;
        pend_op      <= exp_op;
        pend_sel     <= exp_sel;
        pend_rd      <= exp_rd;
        pend_imm     <= exp_imm;
        pend_addr    <= exp_addr;
        pend_strobes <= exp_strobes;
        pend_fetch   <= exp_fetch;
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: test %0d %s is %h, expected %h",
                     $time, cur_test, name, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic close_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", cur_test, test_errors);
        end
        have_test = 1'b0;
    endtask

    always @(negedge clk) begin
        logic [7:0] got_strobes;
        got_strobes = {exec_cmd.exec_en, exec_cmd.imm_valid, ctrl_cmd.call, ctrl_cmd.branch,
                       ctrl_cmd.ret, ctrl_cmd.soft_rst, ctrl_cmd.halted, illegal_inst};
        if (pend_valid) begin
            if (have_test && pend_test != cur_test) begin
                close_test();
            end
            if (!have_test) begin
                cur_test    = pend_test;
                have_test   = 1'b1;
                test_errors = 0;
            end
            compare_field("strobes", 32'(got_strobes), 32'(pend_strobes));
            compare_field("ctrl exec_en", 32'(ctrl_cmd.exec_en), 32'(pend_strobes[7]));
            compare_field("fetch_en", 32'(ctrl_cmd.fetch_en), 32'(pend_fetch));
            if (pend_mask[0]) compare_field("op", 32'(exec_cmd.op), 32'(pend_op));
            if (pend_mask[1]) begin
                compare_field("selects", 32'({exec_cmd.src0_sel, exec_cmd.src1_sel,
                                              exec_cmd.dst_sel}), 32'(pend_sel));
            end
            if (pend_mask[2]) begin
                compare_field("read enables",
                              32'({exec_cmd.src0_rd_en, exec_cmd.src1_rd_en}), 32'(pend_rd));
            end
            if (pend_mask[3]) compare_field("imm_val", 32'(exec_cmd.imm_val), 32'(pend_imm));
            if (pend_mask[4]) compare_field("addr", 32'(exec_cmd.addr), 32'(pend_addr));
        end
        if (report_req && !report_done) begin
            if (have_test) close_test();
            $display("tests run %0d, failed %0d, errors %0d",
                     tests_run, tests_failed, error_count);
            report_done = 1'b1;
        end
    end

endmodule

// File: testbench/inst_decode_tb.sv
`timescale 1ns/10ps

`include "decode_cfg.svh"

module inst_decode_tb;

    localparam int FIELDS     = 11;   // values per row of the data file
    localparam int MAX_ROWS   = 128;
    localparam int CLK_PERIOD = 100;
    localparam int END_TEST   = 32'hff;

    logic                      clk;
    logic                      reset_;
    logic                      inst_valid;
    logic [`INST_W-1:0]        inst;
    decode_pkg::status_reg_t   status;
    decode_pkg::exec_cmd_t     exec_cmd;
    decode_pkg::cpu_ctrl_cmd_t ctrl_cmd;
    logic                      illegal_inst;

    logic [31:0] rows [0:MAX_ROWS*FIELDS-1];
    int          num_rows;
    logic        rows_ready;

    logic        exp_valid;
    logic [7:0]  exp_test;
    logic [7:0]  exp_mask;
    logic [3:0]  exp_op;
    logic [5:0]  exp_sel;
    logic [1:0]  exp_rd;
    logic [7:0]  exp_imm;
    logic [10:0] exp_addr;
    logic [7:0]  exp_strobes;
    logic        exp_fetch;
    logic        report_req;
    logic        report_done;
    int          error_count;

    inst_decode DUT (
        .clk          (clk),
        .reset_       (reset_),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .status       (status),
        .exec_cmd     (exec_cmd),
        .ctrl_cmd     (ctrl_cmd),
        .illegal_inst (illegal_inst)
    );

    inst_decode_monitor u_monitor (
        .clk          (clk),
        .exp_valid    (exp_valid),
        .exp_test     (exp_test),
        .exp_mask     (exp_mask),
        .exp_op       (exp_op),
        .exp_sel      (exp_sel),
        .exp_rd       (exp_rd),
        .exp_imm      (exp_imm),
        .exp_addr     (exp_addr),
        .exp_strobes  (exp_strobes),
        .exp_fetch    (exp_fetch),
        .exec_cmd     (exec_cmd),
        .ctrl_cmd     (ctrl_cmd),
        .illegal_inst (illegal_inst),
        .report_req   (report_req),
        .report_done  (report_done),
        .error_count  (error_count)
    );

    bind inst_decode inst_decode_chk u_chk (
        .clk          (clk),
        .reset_       (reset_),
        .inst_valid   (inst_valid),
        .decoded      (decoded),
        .exec_cmd     (exec_cmd),
        .ctrl_cmd     (ctrl_cmd),
        .illegal_inst (illegal_inst)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic drive_idle();
        inst_valid = 1'b0;
        exp_valid  = 1'b0;
    endtask

    // byte and its expected record go out together
    task automatic drive_row(input int r);
        int base;
        base        = r * FIELDS;
        inst_valid  = 1'b1;
        inst        = rows[base + 1][7:0];
        status      = decode_pkg::status_reg_t'(rows[base + 2][7:0]);
        exp_valid   = 1'b1;
        exp_test    = rows[base][7:0];
        exp_mask    = rows[base + 3][7:0];
        exp_op      = rows[base + 4][3:0];
        exp_sel     = rows[base + 5][5:0];
        exp_rd      = rows[base + 6][1:0];
        exp_imm     = rows[base + 7][7:0];
        exp_addr    = rows[base + 8][10:0];
        exp_strobes = rows[base + 9][7:0];
        exp_fetch   = rows[base + 10][0];
    endtask

    initial begin
        int prev_test;
        clk         = 1'b0;
        reset_      = 1'b0;
        inst        = '0;
        status      = '0;
        exp_test    = '0;
        exp_mask    = '0;
        exp_op      = '0;
        exp_sel     = '0;
        exp_rd      = '0;
        exp_imm     = '0;
        exp_addr    = '0;
        exp_strobes = '0;
        exp_fetch   = 1'b0;
        report_req  = 1'b0;
        num_rows    = 0;
        rows_ready  = 1'b0;
        drive_idle();

        $readmemh("testbench/decode_input.txt", rows);
        while (num_rows < MAX_ROWS && rows[num_rows * FIELDS] != END_TEST) begin
            num_rows++;
        end
        rows_ready = 1'b1;

        repeat (10) @(posedge clk);
        #1 reset_ = 1'b1;

        prev_test = (num_rows > 0) ? int'(rows[0]) : 0;
        for (int r = 0; r < num_rows; r++) begin
            @(posedge clk);
            #1;
            if (int'(rows[r * FIELDS]) != prev_test) begin
                drive_idle();   // gap between tests
                @(posedge clk);
                #1;
                prev_test = int'(rows[r * FIELDS]);
            end
            drive_row(r);
        end
        @(posedge clk);
        #1 drive_idle();

        report_req = 1'b1;
        wait (report_done);
        if (num_rows == 0) begin
            $display("no test rows were read from testbench/decode_input.txt");
        end
        if (num_rows > 0 && error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (rows_ready === 1'b1);
        #((2 * num_rows + 10) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", 2 * num_rows + 10);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: testbench/decode_input.txt
// test inst status mask(op,sel,rd,imm,addr) op sel{s0,s1,d} rd{s0,s1} imm addr
// strobes{exec_en,imm_valid,call,branch,ret,soft_rst,halted,illegal} fetch_en
01 26 00 07 2 1A 3 00 000 80 1
01 4C 00 07 3 30 3 00 000 80 1
01 6B 00 07 4 2F 3 00 000 80 1
01 81 00 07 5 05 3 00 000 80 1
01 A5 00 07 6 15 3 00 000 80 1
02 39 00 07 2 21 2 00 000 80 1
02 5A 00 0D 2 00 0 5A 000 40 1
02 9F 00 07 5 33 2 00 000 80 1
02 C3 00 0D 5 00 0 C3 000 40 1
02 52 00 07 3 02 2 00 000 80 1
02 01 00 0D 3 00 0 01 000 40 1
02 74 00 07 4 10 2 00 000 80 1
02 FF 00 0D 4 00 0 FF 000 40 1
02 BE 00 07 6 32 2 00 000 80 1
02 80 00 0D 6 00 0 80 000 40 1
03 D5 00 07 7 02 0 00 000 80 1
03 3C 00 11 7 00 0 00 53C 40 1
03 EA 00 07 8 10 2 00 000 80 1
03 99 00 11 8 00 0 00 299 40 1
04 13 00 07 9 00 0 00 000 80 1
04 44 00 11 9 00 0 00 344 50 1
04 1F 00 07 A 00 0 00 000 80 1
04 01 00 11 A 00 0 00 701 60 1
05 04 00 01 1 00 0 00 000 80 1
05 10 00 07 9 00 0 00 000 80 1
05 20 08 11 9 00 0 00 020 50 1
05 10 00 07 9 00 0 00 000 80 1
05 21 04 11 9 00 0 00 021 40 1
05 05 00 01 1 00 0 00 000 80 1
05 18 00 07 A 00 0 00 000 80 1
05 30 04 11 A 00 0 00 030 60 1
05 18 00 07 A 00 0 00 000 80 1
05 31 08 11 A 00 0 00 031 40 1
05 06 00 01 1 00 0 00 000 80 1
05 10 00 07 9 00 0 00 000 80 1
05 40 00 11 9 00 0 00 040 50 1
06 02 00 01 0 00 0 00 000 82 0
06 01 00 01 B 00 0 00 000 88 0
06 10 00 07 9 00 0 00 000 80 0
06 00 00 11 9 00 0 00 000 50 1
06 03 00 01 0 00 0 00 000 84 1
06 00 00 01 0 00 0 00 000 80 1
07 08 00 01 0 00 0 00 000 81 1
07 07 00 01 0 00 0 00 000 81 1
07 00 00 01 0 00 0 00 000 80 1
// end of table
FF 00 00 00 0 00 0 00 000 00 0

// File: compile.f
+incdir+common
common/isa_pkg.sv
common/decode_pkg.sv
decode/opcode_decoder.sv
decode/operand_sequencer.sv
logic/branch_condition.sv
logic/inst_decode.sv
testbench/inst_decode_chk.sv
testbench/inst_decode_monitor.sv
testbench/inst_decode_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the inst_decode testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_inst_decode

verilator --binary --timing --assert \
    --top-module inst_decode_tb \
    --Mdir "$OBJ" -o "$BIN" \
    -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^All tests passed!$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
